// ==== rtl/intCtlPkg.sv ====
// interrupt controller shared types
// register words, set fields, sequencer states and control outputs
package intCtlPkg;

    // one interrupt register word
    typedef logic [31:0] word_t;

    // word offset inside a register set, in address order
    typedef enum logic [2:0] {
        FIELD_ACCEL  = 3'd0,
        FIELD_IPC    = 3'd1,
        FIELD_ERROR  = 3'd2,
        FIELD_S2V    = 3'd3,
        FIELD_TID    = 3'd4,
        FIELD_IRQ    = 3'd5,
        FIELD_SP     = 3'd6,
        FIELD_SPACER = 3'd7
    } regField_e;

    // thread handover sequencer states
    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        PC_SWAP,
        WAIT_IRQ,
        REVERT_WARP
    } hwIntState_e;

    // controls toward the SIMT core
    typedef struct packed {
        logic maskActWarp;
        logic hwInt;
        logic maskThreads;
        logic swapPC;
    } intControls_t;

    localparam int DEFAULT_NUM_SETS = 32;

endpackage

// ==== rtl/csrAccessIf.sv ====
// decoded register access
// one bus port's set index, field and strobes toward the register bank
`timescale 1ns/1ps

interface csrAccessIf #(
    parameter int NUM_SETS = intCtlPkg::DEFAULT_NUM_SETS
);

    // already range checked by the decoder
    logic                          rd;
    logic                          wr;
    logic [$clog2(NUM_SETS)-1:0]   setIdx;
    intCtlPkg::regField_e          field;
    intCtlPkg::word_t              storeData;

    // zero whenever rd is low
    intCtlPkg::word_t              loadData;

    modport port (
        output rd,
        output wr,
        output setIdx,
        output field,
        output storeData,
        input  loadData
    );

    modport bank (
        input  rd,
        input  wr,
        input  setIdx,
        input  field,
        input  storeData,
        output loadData
    );

endinterface

// ==== rtl/seqUpdateIf.sv ====
// sequencer link to the register bank
// set-0 status toward the sequencer, set-0 update strobes back to the bank
`timescale 1ns/1ps

interface seqUpdateIf;

    // current set-0 words
    intCtlPkg::word_t s2v0;
    intCtlPkg::word_t ipc0;

    // single cycle update strobes for set 0
    logic             clearError;
    logic             setError;
    logic             clearS2v;
    logic             saveIpc;
    intCtlPkg::word_t ipcValue;

    modport seq (
        input  s2v0,
        input  ipc0,
        output clearError,
        output setError,
        output clearS2v,
        output saveIpc,
        output ipcValue
    );

    modport bank (
        output s2v0,
        output ipc0,
        input  clearError,
        input  setError,
        input  clearS2v,
        input  saveIpc,
        input  ipcValue
    );

endinterface

// ==== rtl/csrAccessPort.sv ====
// register bus port decoder
// splits a byte address into set index and field, drops out-of-range accesses
`timescale 1ns/1ps

module csrAccessPort #(
    parameter int NUM_SETS = intCtlPkg::DEFAULT_NUM_SETS
) (
    input  logic              Rd,
    input  logic              Wr,
    input  intCtlPkg::word_t  Addr,
    input  intCtlPkg::word_t  Store,
    output intCtlPkg::word_t  Load,

    csrAccessIf.port          acc
);

    localparam int IDX_W = $clog2(NUM_SETS);

    // full set number before the range check
    intCtlPkg::word_t setNum;
    logic             inRange;

    //************************************************************
    // address split
    //************************************************************

    // each set spans 32 bytes, 8 words
    assign setNum  = Addr >> 5;
    assign inRange = (setNum < intCtlPkg::word_t'(NUM_SETS));

    assign acc.setIdx = setNum[IDX_W-1:0];
    // byte offset bits 1:0 are ignored
    assign acc.field  = intCtlPkg::regField_e'(Addr[4:2]);

    //************************************************************
    // strobes and data
    //************************************************************

    // out-of-range accesses never reach the bank,
    // so the write is lost and the read comes back as zero
    assign acc.rd        = Rd & inRange;
    assign acc.wr        = Wr & inRange;
    assign acc.storeData = Store;

    assign Load = acc.loadData;

endmodule

// ==== rtl/intRegBank.sv ====
// interrupt register bank
// NUM_SETS sets of eight words, two software ports and the sequencer port
`timescale 1ns/1ps

module intRegBank #(
    parameter int NUM_SETS = intCtlPkg::DEFAULT_NUM_SETS
) (
    input  logic     clk,
    input  logic     reset,

    csrAccessIf.bank scalarAcc,
    csrAccessIf.bank simtAcc,
    seqUpdateIf.bank upd
);

    // set x word
    intCtlPkg::word_t regs     [NUM_SETS][8];
    intCtlPkg::word_t nextRegs [NUM_SETS][8];

    //************************************************************
    // software reads
    //************************************************************

    // combinational, no stall
    assign scalarAcc.loadData = scalarAcc.rd ?
        regs[scalarAcc.setIdx][scalarAcc.field] : '0;
    assign simtAcc.loadData   = simtAcc.rd ?
        regs[simtAcc.setIdx][simtAcc.field] : '0;

    // set 0 status for the sequencer
    assign upd.s2v0 = regs[0][intCtlPkg::FIELD_S2V];
    assign upd.ipc0 = regs[0][intCtlPkg::FIELD_IPC];

    //************************************************************
    // next value with write priority
    //************************************************************

    // applied lowest priority first so the later source wins:
    // scalar, then SIMT, then sequencer
    always_comb
    begin
        nextRegs = regs;

        if (scalarAcc.wr)
        begin
            nextRegs[scalarAcc.setIdx][scalarAcc.field] = scalarAcc.storeData;
        end

        if (simtAcc.wr)
        begin
            nextRegs[simtAcc.setIdx][simtAcc.field] = simtAcc.storeData;
        end

        // sequencer only touches set 0
        if (upd.clearError)
        begin
            nextRegs[0][intCtlPkg::FIELD_ERROR] = '0;
        end
        if (upd.setError)
        begin
            nextRegs[0][intCtlPkg::FIELD_ERROR] = 32'd1;
        end
        if (upd.clearS2v)
        begin
            nextRegs[0][intCtlPkg::FIELD_S2V] = '0;
        end
        if (upd.saveIpc)
        begin
            // interrupted thread PC
            nextRegs[0][intCtlPkg::FIELD_IPC] = upd.ipcValue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            regs <= '{default: '0};
        end
        else
        begin
            regs <= nextRegs;
        end
    end

endmodule

// ==== rtl/intSequencer.sv ====
// hardware interrupt sequencer
// hands a SIMT thread to the interrupt routine and back, driven by set-0 S2V
`timescale 1ns/1ps

module intSequencer (
    input  logic                    clk,
    input  logic                    reset,

    // SIMT pipeline status
    input  logic                    err,
    input  logic                    pipeClean,
    input  intCtlPkg::word_t        pc,

    seqUpdateIf.seq                 upd,

    output intCtlPkg::intControls_t controls,
    output logic                    revertWarp,
    output intCtlPkg::word_t        restorePc
);

    intCtlPkg::hwIntState_e currState;
    intCtlPkg::hwIntState_e nextState;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            currState <= intCtlPkg::IDLE;
        end
        else
        begin
            currState <= nextState;
        end
    end

    // captured PC only matters while saveIpc is high
    assign upd.ipcValue = pc;

    //************************************************************
    // next state and outputs
    //************************************************************
    always_comb
    begin
        nextState      = currState;
        controls       = '0;
        revertWarp     = 1'b0;
        restorePc      = '0;
        upd.clearError = 1'b0;
        upd.setError   = 1'b0;
        upd.clearS2v   = 1'b0;
        upd.saveIpc    = 1'b0;

        case (currState)
            intCtlPkg::IDLE:
            begin
                // new request, stale error goes away on entry
                if (upd.s2v0 == 32'd1)
                begin
                    nextState      = intCtlPkg::WAIT;
                    upd.clearError = 1'b1;
                end
            end
            intCtlPkg::WAIT:
            begin
                controls.maskActWarp = 1'b1;
                controls.hwInt       = 1'b1;
                if (err)
                begin
                    // failed request, acked by dropping S2V
                    nextState    = intCtlPkg::IDLE;
                    upd.setError = 1'b1;
                    upd.clearS2v = 1'b1;
                end
                else if (pipeClean)
                begin
                    nextState = intCtlPkg::PC_SWAP;
                end
            end
            intCtlPkg::PC_SWAP:
            begin
                controls.hwInt       = 1'b1;
                controls.maskThreads = 1'b1;
                controls.swapPC      = 1'b1;
                upd.saveIpc          = 1'b1;
                nextState            = intCtlPkg::WAIT_IRQ;
            end
            intCtlPkg::WAIT_IRQ:
            begin
                controls.hwInt       = 1'b1;
                controls.maskThreads = 1'b1;
                // routine finished once software clears S2V
                if (upd.s2v0 == 32'd0)
                begin
                    nextState = intCtlPkg::REVERT_WARP;
                end
            end
            intCtlPkg::REVERT_WARP:
            begin
                revertWarp = 1'b1;
                restorePc  = upd.ipc0;
                nextState  = intCtlPkg::IDLE;
            end
            default:
            begin
                nextState = intCtlPkg::IDLE;
            end
        endcase
    end

endmodule

// ==== rtl/intCtlTop.sv ====
// interrupt controller top level
// scalar and SIMT bus decoders, the register bank and the handover sequencer
`timescale 1ns/1ps

module intCtlTop #(
    parameter int NUM_SETS = intCtlPkg::DEFAULT_NUM_SETS
) (
    input  logic             clk,
    input  logic             reset,

    // scalar core register bus
    input  logic             scalarRd,
    input  logic             scalarWr,
    input  intCtlPkg::word_t scalarAddr,
    input  intCtlPkg::word_t scalarStore,
    output intCtlPkg::word_t scalarLoad,

    // SIMT core register bus
    input  logic             simtRd,
    input  logic             simtWr,
    input  intCtlPkg::word_t simtAddr,
    input  intCtlPkg::word_t simtStore,
    output intCtlPkg::word_t simtLoad,

    // SIMT pipeline status
    input  logic             err,
    input  logic             pipeClean,
    input  intCtlPkg::word_t pc,

    // SIMT controls
    output logic             maskActWarp,
    output logic             hwInt,
    output logic             maskThreads,
    output logic             swapPC,
    output logic             revertWarp,
    output intCtlPkg::word_t restorePc
);

    intCtlPkg::intControls_t controls;

    csrAccessIf #(.NUM_SETS(NUM_SETS)) scalarAcc ();
    csrAccessIf #(.NUM_SETS(NUM_SETS)) simtAcc ();
    seqUpdateIf                        upd ();

    csrAccessPort #(.NUM_SETS(NUM_SETS)) scalarPort (
        .Rd    (scalarRd),
        .Wr    (scalarWr),
        .Addr  (scalarAddr),
        .Store (scalarStore),
        .Load  (scalarLoad),
        .acc   (scalarAcc)
    );

    csrAccessPort #(.NUM_SETS(NUM_SETS)) simtPort (
        .Rd    (simtRd),
        .Wr    (simtWr),
        .Addr  (simtAddr),
        .Store (simtStore),
        .Load  (simtLoad),
        .acc   (simtAcc)
    );

    intRegBank #(.NUM_SETS(NUM_SETS)) intRegBank_i (
        .clk       (clk),
        .reset     (reset),
        .scalarAcc (scalarAcc),
        .simtAcc   (simtAcc),
        .upd       (upd)
    );

    intSequencer intSequencer_i (
        .clk        (clk),
        .reset      (reset),
        .err        (err),
        .pipeClean  (pipeClean),
        .pc         (pc),
        .upd        (upd),
        .controls   (controls),
        .revertWarp (revertWarp),
        .restorePc  (restorePc)
    );

    // control struct out to plain ports
    assign maskActWarp = controls.maskActWarp;
    assign hwInt       = controls.hwInt;
    assign maskThreads = controls.maskThreads;
    assign swapPC      = controls.swapPC;

endmodule

// ==== dv/intCtl_props.sv ====
// interrupt sequencer properties
// checks swapPC, revertWarp and idle controls against the sequencer state
`timescale 1ns/1ps

module intCtlProps (
    input logic                    clk,
    input logic                    reset,
    input intCtlPkg::hwIntState_e  currState,
    input intCtlPkg::intControls_t controls,
    input logic                    revertWarp
);

    // swapPC belongs to PC_SWAP only
    swapInSwapState: assert property (@(posedge clk) disable iff (reset)
        controls.swapPC |-> (currState == intCtlPkg::PC_SWAP))
        else $error("swapPC high outside PC_SWAP");

    swapSingleCycle: assert property (@(posedge clk) disable iff (reset)
        controls.swapPC |=> !controls.swapPC)
        else $error("swapPC high for more than one cycle");

    // revert always hands back to IDLE
    revertThenIdle: assert property (@(posedge clk) disable iff (reset)
        revertWarp |=> (currState == intCtlPkg::IDLE))
        else $error("revertWarp not followed by IDLE");

    idleQuiet: assert property (@(posedge clk) disable iff (reset)
        (currState == intCtlPkg::IDLE) |-> (controls == '0 && !revertWarp))
        else $error("control output high during IDLE");

endmodule

// ==== dv/intCtlTb.sv ====
// interrupt controller testbench
// random register traffic on both buses, then the interrupt and error paths
`timescale 1ns/1ps

module intCtlTb;

    localparam int NUM_SETS      = 32;
    localparam int RANDOM_ITERS  = 40;
    localparam int COLLIDE_ITERS = 6;
    localparam int RANGE_ITERS   = 6;
    // reset, the five tests and one closing idle cycle per test
    localparam int RUN_CYCLES     = 16 + RANDOM_ITERS * 2 + COLLIDE_ITERS * 4
                                    + RANGE_ITERS * 3 + 10 + 6 + 5;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    localparam intCtlPkg::word_t IPC0_ADDR   = 32'h4;
    localparam intCtlPkg::word_t ERROR0_ADDR = 32'h8;
    localparam intCtlPkg::word_t S2V0_ADDR   = 32'hc;

    // bit order maskActWarp, hwInt, maskThreads, swapPC
    localparam intCtlPkg::intControls_t CTL_IDLE = 4'b0000;
    localparam intCtlPkg::intControls_t CTL_WAIT = 4'b1100;
    localparam intCtlPkg::intControls_t CTL_SWAP = 4'b0111;
    localparam intCtlPkg::intControls_t CTL_IRQ  = 4'b0110;

    logic             clk;
    logic             reset;
    logic             scalarRd;
    logic             scalarWr;
    intCtlPkg::word_t scalarAddr;
    intCtlPkg::word_t scalarStore;
    intCtlPkg::word_t scalarLoad;
    logic             simtRd;
    logic             simtWr;
    intCtlPkg::word_t simtAddr;
    intCtlPkg::word_t simtStore;
    intCtlPkg::word_t simtLoad;
    logic             err;
    logic             pipeClean;
    intCtlPkg::word_t pc;
    logic             maskActWarp;
    logic             hwInt;
    logic             maskThreads;
    logic             swapPC;
    logic             revertWarp;
    intCtlPkg::word_t restorePc;

    // shadow of the register sets
    intCtlPkg::word_t shadow [NUM_SETS][8];
    intCtlPkg::word_t rngState = 32'hc1bb;

    // what the next bus cycle drives besides the buses
    logic                    errNext;
    logic                    cleanNext;
    intCtlPkg::word_t        pcNext;
    logic                    ctlArmed;
    intCtlPkg::intControls_t ctlNext;
    logic                    revertNext;
    intCtlPkg::word_t        restoreNext;

    // expectations for the cycle under way
    string                   cmpName;
    logic                    cmpRd;
    logic                    cmpCtl;
    intCtlPkg::word_t        expScalarLoad;
    intCtlPkg::word_t        expSimtLoad;
    intCtlPkg::regField_e    expScalarField;
    intCtlPkg::intControls_t expCtl;
    logic                    expRevert;
    intCtlPkg::word_t        expRestore;

    int errCount;
    int errStart;
    int checkCount;
    int testCount;
    int failedTests;
    int cycleCount;

    intCtlTop #(.NUM_SETS(NUM_SETS)) intCtlTop_i (.*);

    bind intSequencer intCtlProps intCtlProps_i (
        .clk        (clk),
        .reset      (reset),
        .currState  (currState),
        .controls   (controls),
        .revertWarp (revertWarp)
    );

    always #4 clk = ~clk;

    //************************************************************
    // reference model and random source
    //************************************************************

    function automatic intCtlPkg::word_t xorshift();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic inRange(input intCtlPkg::word_t addr);
        return (addr >> 5) < NUM_SETS;
    endfunction

    // load seen on a bus in the current cycle
    function automatic intCtlPkg::word_t expectLoad(input logic rd, input intCtlPkg::word_t addr);
        if (!rd || !inRange(addr))
            return '0;
        return shadow[addr >> 5][addr[4:2]];
    endfunction

    function automatic intCtlPkg::word_t randomAddr();
        intCtlPkg::word_t a;
        a = xorshift() & 32'h3ff;
        // set-0 S2V would start the sequencer
        if (a[9:2] == 8'h03)
            a[4:2] = 3'd4;
        return a;
    endfunction

    //************************************************************
    // compare tasks and the comparing process
    //************************************************************

    task automatic checkWord(input string name, input intCtlPkg::word_t exp,
                             input intCtlPkg::word_t act);
        checkCount++;
        if (act !== exp)
        begin
            errCount++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkField(input string name, input intCtlPkg::regField_e exp,
                              input intCtlPkg::regField_e act);
        checkCount++;
        if (act !== exp)
        begin
            errCount++;
            $display("FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic checkCtl(input string name, input intCtlPkg::intControls_t exp,
                            input intCtlPkg::intControls_t act);
        checkCount++;
        if (act !== exp)
        begin
            errCount++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (cmpRd)
        begin
            checkWord({cmpName, " scalarLoad"}, expScalarLoad, scalarLoad);
            checkWord({cmpName, " simtLoad"}, expSimtLoad, simtLoad);
            checkField({cmpName, " scalar field"}, expScalarField,
                       intCtlTop_i.scalarAcc.field);
        end
        if (cmpCtl)
        begin
            checkCtl({cmpName, " controls"}, expCtl,
                     {maskActWarp, hwInt, maskThreads, swapPC});
            checkWord({cmpName, " revertWarp"}, 32'(expRevert), 32'(revertWarp));
            checkWord({cmpName, " restorePc"}, expRestore, restorePc);
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    //************************************************************
    // stimulus tasks
    //************************************************************

    // one clock of traffic on both buses
    task automatic busCycle(
        input string            name,
        input logic             sRd,
        input logic             sWr,
        input intCtlPkg::word_t sAddr,
        input intCtlPkg::word_t sStore,
        input logic             vRd,
        input logic             vWr,
        input intCtlPkg::word_t vAddr,
        input intCtlPkg::word_t vStore
    );
        @(posedge clk);
        scalarRd    <= sRd;
        scalarWr    <= sWr;
        scalarAddr  <= sAddr;
        scalarStore <= sStore;
        simtRd      <= vRd;
        simtWr      <= vWr;
        simtAddr    <= vAddr;
        simtStore   <= vStore;
        err         <= errNext;
        pipeClean   <= cleanNext;
        pc          <= pcNext;
        // reads see the sets as they were before this cycle's writes
        cmpName        <= name;
        cmpRd          <= 1'b1;
        expScalarLoad  <= expectLoad(sRd, sAddr);
        expSimtLoad    <= expectLoad(vRd, vAddr);
        expScalarField <= intCtlPkg::regField_e'(sAddr[4:2]);
        cmpCtl         <= ctlArmed;
        expCtl         <= ctlNext;
        expRevert      <= revertNext;
        expRestore     <= restoreNext;
        ctlArmed  = 1'b0;
        errNext   = 1'b0;
        cleanNext = 1'b0;
        // SIMT lands last and wins a shared word
        if (sWr && inRange(sAddr))
            shadow[sAddr >> 5][sAddr[4:2]] = sStore;
        if (vWr && inRange(vAddr))
            shadow[vAddr >> 5][vAddr[4:2]] = vStore;
    endtask

    task automatic busIdle(input string name);
        busCycle(name, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic armCtl(input intCtlPkg::intControls_t exp, input logic revert,
                          input intCtlPkg::word_t restore);
        ctlArmed    = 1'b1;
        ctlNext     = exp;
        revertNext  = revert;
        restoreNext = restore;
    endtask

    task automatic finishTest(input string name);
        busIdle(name);
        @(negedge clk);
        #1;
        testCount++;
        if (errCount != errStart)
            failedTests++;
        $display("test %-16s %0d errors", name, errCount - errStart);
        errStart = errCount;
    endtask

    //************************************************************
    // tests
    //************************************************************

    task automatic runRandom();
        string            name;
        intCtlPkg::word_t addr;
        intCtlPkg::word_t other;
        intCtlPkg::word_t data;
        intCtlPkg::word_t pick;
        name = "random access";
        // straight out of reset every control is low
        armCtl(CTL_IDLE, 1'b0, '0);
        for (int i = 0; i < RANDOM_ITERS; i++)
        begin
            addr  = randomAddr();
            other = randomAddr();
            data  = xorshift();
            pick  = xorshift();
            if (pick[0])
                busCycle(name, 1'b0, 1'b1, addr, data, 1'b0, 1'b0, '0, '0);
            else
                busCycle(name, 1'b0, 1'b0, '0, '0, 1'b0, 1'b1, addr, data);
            // read back on either bus, the other one reads elsewhere
            // or points at the fresh word with its read strobe low
            if (pick[1])
                busCycle(name, 1'b1, 1'b0, addr, '0,
                         pick[2], 1'b0, pick[2] ? other : addr, '0);
            else
                busCycle(name, pick[2], 1'b0, pick[2] ? other : addr, '0,
                         1'b1, 1'b0, addr, '0);
        end
        finishTest(name);
    endtask

    task automatic runCollide();
        string            name;
        intCtlPkg::word_t addrA;
        intCtlPkg::word_t addrB;
        intCtlPkg::word_t d1;
        intCtlPkg::word_t d2;
        name = "same cycle";
        for (int i = 0; i < COLLIDE_ITERS; i++)
        begin
            addrA = randomAddr();
            if (addrA[9:5] == 5'd0)
                addrA[5] = 1'b1;
            addrB      = addrA;
            addrB[4:2] = addrA[4:2] + 3'd1;
            d1 = xorshift();
            d2 = xorshift();
            busCycle(name, 1'b0, 1'b1, addrA, d1, 1'b0, 1'b1, addrA, d2);
            busCycle(name, 1'b1, 1'b0, addrA, '0, 1'b1, 1'b0, addrA, '0);
            busCycle(name, 1'b0, 1'b1, addrA, ~d2, 1'b0, 1'b1, addrB, d1);
            busCycle(name, 1'b1, 1'b0, addrA, '0, 1'b1, 1'b0, addrB, '0);
        end
        finishTest(name);
    endtask

    task automatic runRange();
        string            name;
        intCtlPkg::word_t near;
        intCtlPkg::word_t far;
        intCtlPkg::word_t data;
        name = "out of range";
        for (int i = 0; i < RANGE_ITERS; i++)
        begin
            near = randomAddr();
            data = xorshift();
            // same low bits as near, set index 32 or more
            far  = near | (xorshift() & 32'hfffffc00);
            if (far[31:10] == '0)
                far[10] = 1'b1;
            busCycle(name, 1'b0, 1'b1, near, data, 1'b0, 1'b0, '0, '0);
            busCycle(name, 1'b0, 1'b1, far, ~data, 1'b0, 1'b1, far, data ^ 32'h5a5a);
            busCycle(name, 1'b1, 1'b0, far, '0, 1'b1, 1'b0, near, '0);
        end
        finishTest(name);
    endtask

    task automatic runInterrupt();
        string            name;
        intCtlPkg::word_t pcVal;
        name   = "full interrupt";
        pcVal  = xorshift();
        pcNext = pcVal;
        armCtl(CTL_IDLE, 1'b0, '0);
        busCycle(name, 1'b0, 1'b1, S2V0_ADDR, 32'd1, 1'b0, 1'b0, '0, '0);
        armCtl(CTL_IDLE, 1'b0, '0);
        busIdle(name);
        // WAIT while the pipeline drains
        armCtl(CTL_WAIT, 1'b0, '0);
        busIdle(name);
        armCtl(CTL_WAIT, 1'b0, '0);
        cleanNext = 1'b1;
        busIdle(name);
        armCtl(CTL_SWAP, 1'b0, '0);
        busIdle(name);
        shadow[0][intCtlPkg::FIELD_IPC] = pcVal;
        armCtl(CTL_IRQ, 1'b0, '0);
        busCycle(name, 1'b1, 1'b0, IPC0_ADDR, '0, 1'b0, 1'b0, '0, '0);
        // routine done, software drops S2V
        armCtl(CTL_IRQ, 1'b0, '0);
        busCycle(name, 1'b0, 1'b0, '0, '0, 1'b0, 1'b1, S2V0_ADDR, '0);
        armCtl(CTL_IRQ, 1'b0, '0);
        busIdle(name);
        armCtl(CTL_IDLE, 1'b1, pcVal);
        busIdle(name);
        armCtl(CTL_IDLE, 1'b0, '0);
        busCycle(name, 1'b1, 1'b0, S2V0_ADDR, '0, 1'b1, 1'b0, IPC0_ADDR, '0);
        finishTest(name);
    endtask

    task automatic runErrorPath();
        string name;
        name = "error path";
        busCycle(name, 1'b0, 1'b1, ERROR0_ADDR, 32'd1, 1'b0, 1'b0, '0, '0);
        busCycle(name, 1'b1, 1'b0, ERROR0_ADDR, '0, 1'b0, 1'b1, S2V0_ADDR, 32'd1);
        armCtl(CTL_IDLE, 1'b0, '0);
        busIdle(name);
        // stale error is gone on entry to WAIT
        shadow[0][intCtlPkg::FIELD_ERROR] = '0;
        armCtl(CTL_WAIT, 1'b0, '0);
        errNext   = 1'b1;
        cleanNext = 1'b1;
        busCycle(name, 1'b1, 1'b0, ERROR0_ADDR, '0, 1'b0, 1'b0, '0, '0);
        shadow[0][intCtlPkg::FIELD_ERROR] = 32'd1;
        shadow[0][intCtlPkg::FIELD_S2V]   = '0;
        armCtl(CTL_IDLE, 1'b0, '0);
        busCycle(name, 1'b1, 1'b0, ERROR0_ADDR, '0, 1'b1, 1'b0, S2V0_ADDR, '0);
        armCtl(CTL_IDLE, 1'b0, '0);
        busIdle(name);
        finishTest(name);
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        scalarRd    = 1'b0;
        scalarWr    = 1'b0;
        scalarAddr  = '0;
        scalarStore = '0;
        simtRd      = 1'b0;
        simtWr      = 1'b0;
        simtAddr    = '0;
        simtStore   = '0;
        err         = 1'b0;
        pipeClean   = 1'b0;
        pc          = '0;
        errNext     = 1'b0;
        cleanNext   = 1'b0;
        pcNext      = '0;
        ctlArmed    = 1'b0;
        ctlNext     = '0;
        revertNext  = 1'b0;
        restoreNext = '0;
        cmpRd       = 1'b0;
        cmpCtl      = 1'b0;
        errCount    = 0;
        errStart    = 0;
        checkCount  = 0;
        testCount   = 0;
        failedTests = 0;
        cycleCount  = 0;
        shadow      = '{default: '0};

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        runRandom();
        runCollide();
        runRange();
        runInterrupt();
        runErrorPath();

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errCount);
        if (errCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/intCtlPkg.sv
rtl/csrAccessIf.sv
rtl/seqUpdateIf.sv
rtl/csrAccessPort.sv
rtl/intRegBank.sv
rtl/intSequencer.sv
rtl/intCtlTop.sv
dv/intCtl_props.sv
dv/intCtlTb.sv
